/* verilog/vis_pkg.sv */
// VIS control shared definitions
`default_nettype none

package vis_pkg;

   localparam int N_THREADS = 4;

   // Widths with a meaning of their own
   typedef logic [8:0]           opf_t;
   typedef logic [1:0]           tid_t;
   typedef logic [N_THREADS-1:0] thr_t;
   typedef logic [4:0]           freg_t;
   typedef logic [2:0]           gsr_align_t;
   // Bit 2 set means the GSR rounding overrides the FSR
   typedef logic [2:0]           gsr_rnd_t;
   typedef logic [1:0]           fsr_rnd_t;

   // Logic function code in opf bits 4 to 1
   typedef enum logic [3:0] {
      LOG_ZERO    = 4'd0,
      LOG_NOR     = 4'd1,
      LOG_ANDNOT2 = 4'd2,
      LOG_NOT2    = 4'd3,
      LOG_ANDNOT1 = 4'd4,
      LOG_NOT1    = 4'd5,
      LOG_XOR     = 4'd6,
      LOG_NAND    = 4'd7,
      LOG_AND     = 4'd8,
      LOG_XNOR    = 4'd9,
      LOG_SRC1    = 4'd10,
      LOG_ORNOT2  = 4'd11,
      LOG_SRC2    = 4'd12,
      LOG_ORNOT1  = 4'd13,
      LOG_OR      = 4'd14,
      LOG_ONE     = 4'd15
   } log_fn_t;

   // Opcode patterns
   localparam logic [5:0] OPF_ADD_HI    = 6'b001010;
   localparam logic [3:0] OPF_LOGIC_HI  = 4'b0011;
   localparam opf_t       OPF_FALIGN    = 9'h048;
   localparam opf_t       OPF_SIAM      = 9'h081;
   // Bit 1 selects the little-endian form
   localparam opf_t       OPF_ALIGNADDR = 9'h018;

   // State register address of the GSR
   localparam logic [6:0] SRADDR_GSR    = 7'h13;

endpackage

`default_nettype wire

/* verilog/vis_opf_decode.sv */
// VIS opcode decode
`timescale 1ns/100ps
`default_nettype none

module vis_opf_decode import vis_pkg::*; (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  visop_e,
   input  opf_t  opf,
   input  freg_t frs1_e,
   input  freg_t frs2_e,
   input  freg_t frd_e,
   output logic  sel_add,
   output logic  sel_align,
   output logic  sel_log,
   output logic  illegal_vis_e,
   output logic  vis_nofrf_e,
   output logic  subtract,
   output logic  cin,
   output logic  add32,
   output logic  log_sel_pass,
   output logic  log_sel_nand,
   output logic  log_sel_nor,
   output logic  log_sel_xor,
   output logic  log_constant,
   output logic  invert_rs1,
   output logic  invert_rs2,
   output logic  log_pass_rs1,
   output logic  log_pass_rs2,
   output logic  log_pass_const,
   output logic  vis_issue_e,
   output logic  is_siam_e,
   output logic  is_alignaddr_e,
   output logic  little_e
);

   logic    is_add;
   logic    is_align;
   logic    is_logic;
   logic    is_siam;
   logic    is_alignaddr;
   log_fn_t log_fn;
   logic    rs1_chk;
   logic    rs2_chk;
   logic    illegal_rs1;
   logic    illegal_rs2;
   logic    illegal_siam;
   logic    pass_rs1_q;
   logic    pass_rs2_q;

   //////////////////////////////////////////////////
   // Class decode
   //////////////////////////////////////////////////
   assign is_add       = (opf[8:3] == OPF_ADD_HI);
   assign is_align     = (opf == OPF_FALIGN);
   assign is_logic     = (opf[8:5] == OPF_LOGIC_HI);
   assign is_siam      = (opf == OPF_SIAM);
   assign is_alignaddr = ({opf[8:2], 1'b0, opf[0]} == OPF_ALIGNADDR);
   assign log_fn       = log_fn_t'(opf[4:1]);

   assign sel_add   = is_add;
   assign sel_align = is_align;
   assign sel_log   = ~(is_add | is_align);

   // Unused source operands must be f0
   assign rs1_chk = is_siam | (is_logic & (log_fn inside {LOG_ZERO, LOG_ONE, LOG_SRC2, LOG_NOT2}));
   assign rs2_chk = is_logic & (log_fn inside {LOG_ZERO, LOG_ONE, LOG_SRC1, LOG_NOT1});
   assign illegal_rs1  = rs1_chk & (frs1_e != '0);
   assign illegal_rs2  = rs2_chk & (frs2_e != '0);
   assign illegal_siam = is_siam & ((frd_e != '0) | frs2_e[4] | frs2_e[3]);

   assign illegal_vis_e = visop_e & (~(is_add | is_align | is_logic | is_siam | is_alignaddr) |
                                     illegal_rs1 | illegal_rs2 | illegal_siam);
   assign vis_nofrf_e   = visop_e & (is_siam | is_alignaddr |
                                     (is_logic & (log_fn inside {LOG_ZERO, LOG_ONE})));

   assign vis_issue_e    = visop_e & ~illegal_vis_e;
   assign is_siam_e      = is_siam;
   assign is_alignaddr_e = is_alignaddr;
   assign little_e       = is_alignaddr & opf[1];

   //////////////////////////////////////////////////
   // Adder and logic unit controls
   //////////////////////////////////////////////////
   assign cin   = opf[2];
   assign add32 = opf[1];

   assign log_sel_nand = log_fn inside {LOG_OR, LOG_NAND, LOG_ORNOT1, LOG_ORNOT2};
   assign log_sel_xor  = log_fn inside {LOG_XOR, LOG_XNOR};
   assign log_sel_nor  = log_fn inside {LOG_AND, LOG_NOR, LOG_ANDNOT1, LOG_ANDNOT2};
   assign log_sel_pass = log_fn inside {LOG_ZERO, LOG_ONE, LOG_SRC1, LOG_SRC2,
                                        LOG_NOT1, LOG_NOT2};
   assign log_constant = (log_fn == LOG_ONE);

   // Invert and pass controls are used by the datapath in M
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         subtract   <= 1'b0;
         invert_rs1 <= 1'b0;
         invert_rs2 <= 1'b0;
         pass_rs1_q <= 1'b0;
         pass_rs2_q <= 1'b0;
      end else begin
         subtract   <= opf[2];
         invert_rs1 <= log_fn inside {LOG_NOT1, LOG_OR, LOG_AND, LOG_ORNOT2, LOG_ANDNOT2};
         invert_rs2 <= log_fn inside {LOG_NOT2, LOG_OR, LOG_AND, LOG_ORNOT1, LOG_ANDNOT1,
                                      LOG_XNOR};
         pass_rs1_q <= log_fn inside {LOG_SRC1, LOG_NOT1};
         pass_rs2_q <= log_fn inside {LOG_SRC2, LOG_NOT2};
      end
   end

   assign log_pass_rs1   = pass_rs1_q;
   assign log_pass_rs2   = pass_rs2_q & ~pass_rs1_q;
   assign log_pass_const = ~(log_pass_rs1 | log_pass_rs2);

endmodule

`default_nettype wire

/* verilog/vis_pipe.sv */
// VIS valid pipeline
`timescale 1ns/100ps
`default_nettype none

module vis_pipe import vis_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     vis_issue_e,
   input  logic     is_siam_e,
   input  logic     is_alignaddr_e,
   input  logic     little_e,
   input  tid_t     tid_e,
   input  gsr_rnd_t rnd_e,
   input  logic     kill_w,
   input  logic     flush_w2,
   input  logic     ue_trap_w3,
   output logic     siam_w2,
   output logic     alignaddr_w2,
   output logic     little_w2,
   output tid_t     tid_w2,
   output gsr_rnd_t siam_rnd_w2,
   output logic     vis_result,
   output logic     vis_wen_next
);

   logic     vld_m, vld_w, vld_w2, vld_w3;
   // Class bits {siam, alignaddr} per stage
   logic [1:0] cls_m, cls_w, cls_w2, cls_w3;
   logic     little_m, little_w;
   tid_t     tid_m, tid_w;
   gsr_rnd_t rnd_m, rnd_w;

   // Valids, with each kill applied as the op leaves its stage
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         vld_m  <= 1'b0;
         vld_w  <= 1'b0;
         vld_w2 <= 1'b0;
         vld_w3 <= 1'b0;
      end else begin
         vld_m  <= vis_issue_e;
         vld_w  <= vld_m;
         vld_w2 <= vld_w & ~kill_w;
         vld_w3 <= vld_w2 & ~flush_w2;
      end
   end

   // Per-op payload
   always_ff @(posedge clk) begin
      cls_m       <= {is_siam_e, is_alignaddr_e};
      cls_w       <= cls_m;
      cls_w2      <= cls_w;
      cls_w3      <= cls_w2;
      little_m    <= little_e;
      little_w    <= little_m;
      little_w2   <= little_w;
      tid_m       <= tid_e;
      tid_w       <= tid_m;
      tid_w2      <= tid_w;
      rnd_m       <= rnd_e;
      rnd_w       <= rnd_m;
      siam_rnd_w2 <= rnd_w;
   end

   // GSR update strobes for ops that survive W2
   assign siam_w2      = vld_w2 & ~flush_w2 & cls_w2[1];
   assign alignaddr_w2 = vld_w2 & ~flush_w2 & cls_w2[0];

   assign vis_result   = vld_w3 & ~ue_trap_w3;
   assign vis_wen_next = vis_result & ~(|cls_w3);

endmodule

`default_nettype wire

/* verilog/gsr_wr_pipe.sv */
// GSR write pipeline
`timescale 1ns/100ps
`default_nettype none

module gsr_wr_pipe import vis_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  logic [6:0] sraddr_d,
   input  logic       wsr_inst_e,
   input  tid_t       tid_e,
   input  gsr_align_t gsr_align_m,
   input  gsr_rnd_t   gsr_rnd_m,
   input  logic       inst_vld_w,
   input  logic       flush_w2,
   output logic       wgsr_w2,
   output tid_t       wgsr_tid_w2,
   output gsr_align_t align_w2,
   output gsr_rnd_t   rnd_w2
);

   logic       gsr_addr_e;
   logic       wgsr_e;
   logic       wgsr_m, wgsr_w, wgsr_q_w2;
   tid_t       tid_m, tid_w;
   gsr_align_t align_w;
   gsr_rnd_t   rnd_w;

   // Address is known in D, the write itself shows up in E
   assign wgsr_e = wsr_inst_e & gsr_addr_e;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         gsr_addr_e <= 1'b0;
         wgsr_m     <= 1'b0;
         wgsr_w     <= 1'b0;
         wgsr_q_w2  <= 1'b0;
      end else begin
         gsr_addr_e <= (sraddr_d == SRADDR_GSR);
         wgsr_m     <= wgsr_e;
         wgsr_w     <= wgsr_m;
         wgsr_q_w2  <= wgsr_w & inst_vld_w;
      end
   end

   assign wgsr_w2 = wgsr_q_w2 & ~flush_w2;

   // Thread from E, write data from M
   // The align stage also carries the alignaddress offset
   always_ff @(posedge clk) begin
      tid_m       <= tid_e;
      tid_w       <= tid_m;
      wgsr_tid_w2 <= tid_w;
      align_w     <= gsr_align_m;
      align_w2    <= align_w;
      rnd_w       <= gsr_rnd_m;
      rnd_w2      <= rnd_w;
   end

endmodule

`default_nettype wire

/* verilog/gsr_regs.sv */
// Per-thread GSR storage
`timescale 1ns/100ps
`default_nettype none

module gsr_regs import vis_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       wgsr_w2,
   input  tid_t       wgsr_tid_w2,
   input  gsr_align_t align_w2,
   input  gsr_rnd_t   rnd_w2,
   input  logic       siam_w2,
   input  logic       alignaddr_w2,
   input  logic       little_w2,
   input  tid_t       vis_tid_w2,
   input  gsr_rnd_t   siam_rnd_w2,
   input  tid_t       tid_e,
   input  tid_t       fp_tid,
   input  fsr_rnd_t   fsr_rnd,
   output thr_t       gsr_wsr_w2,
   output gsr_align_t rsr_align_m,
   output gsr_rnd_t   rsr_rnd_m,
   output fsr_rnd_t   fpu_rnd,
   output logic       align0,
   output logic       align2,
   output logic       align4,
   output logic       align6,
   output logic       align_odd
);

   gsr_align_t align_q [N_THREADS];
   gsr_rnd_t   rnd_q   [N_THREADS];
   thr_t       vis_thr_w2;
   gsr_align_t alignaddr_data_w2;
   gsr_rnd_t   fp_rnd;
   gsr_align_t fp_align_q;

   //////////////////////////////////////////////////
   // Write side
   //////////////////////////////////////////////////
   assign gsr_wsr_w2 = wgsr_w2 ? (thr_t'(1) << wgsr_tid_w2) : '0;
   assign vis_thr_w2 = thr_t'(1) << vis_tid_w2;

   // Little-endian alignaddress stores the negated offset
   assign alignaddr_data_w2 = little_w2 ? (~align_w2 + 3'd1) : align_w2;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < N_THREADS; i++) begin
            align_q[i] <= '0;
            rnd_q[i]   <= '0;
         end
      end else begin
         for (int i = 0; i < N_THREADS; i++) begin
            // wrgsr takes both fields and wins over VIS updates
            if (gsr_wsr_w2[i]) begin
               align_q[i] <= align_w2;
               rnd_q[i]   <= rnd_w2;
            end else begin
               if (siam_w2 && vis_thr_w2[i]) begin
                  rnd_q[i] <= siam_rnd_w2;
               end
               if (alignaddr_w2 && vis_thr_w2[i]) begin
                  align_q[i] <= alignaddr_data_w2;
               end
            end
         end
      end
   end

   //////////////////////////////////////////////////
   // Read side
   //////////////////////////////////////////////////

   // State register read for the thread in E
   always_ff @(posedge clk) begin
      rsr_align_m <= align_q[tid_e];
      rsr_rnd_m   <= rnd_q[tid_e];
   end

   assign fp_rnd = rnd_q[fp_tid];

   // Rounding and align controls for the FP thread
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fpu_rnd    <= '0;
         fp_align_q <= '0;
      end else begin
         fpu_rnd    <= fp_rnd[2] ? fp_rnd[1:0] : fsr_rnd;
         fp_align_q <= align_q[fp_tid];
      end
   end

   // Byte shift in steps of two, odd byte on top
   assign align0    = ~fp_align_q[2] & ~fp_align_q[1];
   assign align2    = ~fp_align_q[2] &  fp_align_q[1];
   assign align4    =  fp_align_q[2] & ~fp_align_q[1];
   assign align6    =  fp_align_q[2] &  fp_align_q[1];
   assign align_odd =  fp_align_q[0];

endmodule

`default_nettype wire

/* verilog/vis_ctl.sv */
// VIS control top level
`timescale 1ns/100ps
`default_nettype none

module vis_ctl import vis_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   // Decode
   input  logic       visop_e,
   input  opf_t       opf,
   input  freg_t      frs1_e,
   input  freg_t      frs2_e,
   input  freg_t      frd_e,
   output logic       sel_add,
   output logic       sel_align,
   output logic       sel_log,
   output logic       illegal_vis_e,
   output logic       vis_nofrf_e,
   output logic       subtract,
   output logic       cin,
   output logic       add32,
   output logic       log_sel_pass,
   output logic       log_sel_nand,
   output logic       log_sel_nor,
   output logic       log_sel_xor,
   output logic       log_constant,
   output logic       invert_rs1,
   output logic       invert_rs2,
   output logic       log_pass_rs1,
   output logic       log_pass_rs2,
   output logic       log_pass_const,
   // Pipeline
   input  tid_t       tid_e,
   input  gsr_rnd_t   rnd_e,
   input  logic       kill_w,
   input  logic       flush_w2,
   input  logic       ue_trap_w3,
   output logic       vis_result,
   output logic       vis_wen_next,
   // State register write and read
   input  logic [6:0] sraddr_d,
   input  logic       wsr_inst_e,
   input  gsr_align_t gsr_align_m,
   input  gsr_rnd_t   gsr_rnd_m,
   input  logic       inst_vld_w,
   input  tid_t       fp_tid,
   input  fsr_rnd_t   fsr_rnd,
   output thr_t       gsr_wsr_w2,
   output gsr_align_t rsr_align_m,
   output gsr_rnd_t   rsr_rnd_m,
   output fsr_rnd_t   fpu_rnd,
   output logic       align0,
   output logic       align2,
   output logic       align4,
   output logic       align6,
   output logic       align_odd
);

   logic       vis_issue_e, is_siam_e, is_alignaddr_e, little_e;
   logic       siam_w2, alignaddr_w2, little_w2;
   tid_t       vis_tid_w2;
   gsr_rnd_t   siam_rnd_w2;
   logic       wgsr_w2;
   tid_t       wgsr_tid_w2;
   gsr_align_t align_w2;
   gsr_rnd_t   rnd_w2;

   vis_opf_decode u_decode (.*);

   vis_pipe u_vis_pipe (.*, .tid_w2(vis_tid_w2));

   gsr_wr_pipe u_wr_pipe (.*);

   gsr_regs u_gsr_regs (.*);

endmodule

`default_nettype wire

/* dv/tb_vis_ctl.sv */
// VIS control testbench
`timescale 1ns/100ps
`default_nettype none

module tb_vis_ctl import vis_pkg::*; ();

   // 1500 random cycles, three conflict cases of 8 cycles and the drain fit well inside
   localparam int N_OPS          = 1500;
   localparam int TIMEOUT_CYCLES = 2000;

   logic       clk, rst_n;
   logic       visop_e, kill_w, flush_w2, ue_trap_w3, wsr_inst_e, inst_vld_w;
   opf_t       opf;
   freg_t      frs1_e, frs2_e, frd_e;
   tid_t       tid_e, fp_tid;
   gsr_rnd_t   rnd_e, gsr_rnd_m, rsr_rnd_m;
   gsr_align_t gsr_align_m, rsr_align_m;
   fsr_rnd_t   fsr_rnd, fpu_rnd;
   logic [6:0] sraddr_d;
   logic       sel_add, sel_align, sel_log, illegal_vis_e, vis_nofrf_e;
   logic       subtract, cin, add32, log_constant, invert_rs1, invert_rs2;
   logic       log_sel_pass, log_sel_nand, log_sel_nor, log_sel_xor;
   logic       log_pass_rs1, log_pass_rs2, log_pass_const;
   logic       vis_result, vis_wen_next;
   logic       align0, align2, align4, align6, align_odd;
   thr_t       gsr_wsr_w2;

   integer     seed;
   int         cycles;
   int         err_value;
   int         err_other;
   string      test_name;

   vis_ctl u_vis_ctl (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Run stopped after %0d cycles without reaching the end of the tests", cycles);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   task automatic report_mismatch(input string check, input logic [15:0] exp,
                                  input logic [15:0] act);
      err_value++;
      $display("ERR %s/%s expected %h actual %h", test_name, check, exp, act);
   endtask

   task automatic report_failure(input string what);
      err_other++;
      $display("Check failed during %s: %s", test_name, what);
   endtask

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////

   // Class selects and E-stage controls straight from the opcode rules
   function automatic logic [11:0] decode_rules(input logic v, input opf_t op,
                                                input freg_t rs1, input freg_t rs2,
                                                input freg_t rd);
      log_fn_t fn;
      logic    add, aln, lg, sm, aa, bad, nofrf;
      fn    = log_fn_t'(op[4:1]);
      add   = (op[8:3] == OPF_ADD_HI);
      aln   = (op == OPF_FALIGN);
      lg    = (op[8:5] == OPF_LOGIC_HI);
      sm    = (op == OPF_SIAM);
      aa    = ((op & ~9'h002) == OPF_ALIGNADDR);
      bad   = ~(add | aln | lg | sm | aa);
      // Unread sources must be f0
      bad   = bad | ((sm | (lg & (fn inside {LOG_ZERO, LOG_ONE, LOG_SRC2, LOG_NOT2})))
                     & (rs1 != '0));
      bad   = bad | (lg & (fn inside {LOG_ZERO, LOG_ONE, LOG_SRC1, LOG_NOT1}) & (rs2 != '0));
      bad   = bad | (sm & ((rd != '0) | (rs2[4:3] != '0)));
      nofrf = sm | aa | (lg & (fn inside {LOG_ZERO, LOG_ONE}));
      return {add, aln, ~(add | aln), op[2], op[1], fn == LOG_ONE,
              fn inside {LOG_ZERO, LOG_ONE, LOG_SRC1, LOG_SRC2, LOG_NOT1, LOG_NOT2},
              fn inside {LOG_OR, LOG_NAND, LOG_ORNOT1, LOG_ORNOT2},
              fn inside {LOG_AND, LOG_NOR, LOG_ANDNOT1, LOG_ANDNOT2},
              fn inside {LOG_XOR, LOG_XNOR}, v & bad, v & nofrf};
   endfunction

   // Subtract, inverts and pass selects seen in M
   function automatic logic [5:0] m_stage_controls(input opf_t op);
      log_fn_t fn;
      logic    p1, p2;
      fn = log_fn_t'(op[4:1]);
      p1 = fn inside {LOG_SRC1, LOG_NOT1};
      p2 = (fn inside {LOG_SRC2, LOG_NOT2}) & ~p1;
      return {op[2], fn inside {LOG_NOT1, LOG_OR, LOG_AND, LOG_ORNOT2, LOG_ANDNOT2},
              fn inside {LOG_NOT2, LOG_OR, LOG_AND, LOG_ORNOT1, LOG_ANDNOT1, LOG_XNOR},
              p1, p2, ~(p1 | p2)};
   endfunction

   // VIS stages M, W, W2, W3 and wrgsr stages M, W, W2
   logic [3:0] pv;
   logic [1:0] pc [4];
   logic       pl [4];
   tid_t       pt [4];
   gsr_rnd_t   pr [4];
   logic       gaddr;
   logic [2:0] wv;
   tid_t       wt [3];
   gsr_align_t ga_w, ga_w2, fp_align_exp;
   gsr_rnd_t   gr_w, gr_w2;
   gsr_align_t ref_align [N_THREADS];
   gsr_rnd_t   ref_rnd [N_THREADS];
   opf_t       m_opf;
   logic [5:0] rsr_exp;
   fsr_rnd_t   fp_rnd_exp;
   logic       wr_ref_w2, siam_ref_w2, aa_ref_w2, result_ref;
   logic [11:0] dec_exp, dec_act;
   logic [6:0] fp_exp, fp_act;

   assign dec_exp     = decode_rules(visop_e, opf, frs1_e, frs2_e, frd_e);
   assign dec_act     = {sel_add, sel_align, sel_log, cin, add32, log_constant, log_sel_pass,
                         log_sel_nand, log_sel_nor, log_sel_xor, illegal_vis_e, vis_nofrf_e};
   assign wr_ref_w2   = wv[2] & ~flush_w2;
   assign siam_ref_w2 = pv[2] & ~flush_w2 & pc[2][1];
   assign aa_ref_w2   = pv[2] & ~flush_w2 & pc[2][0];
   assign result_ref  = pv[3] & ~ue_trap_w3;
   assign fp_exp      = {fp_rnd_exp, 4'(1) << fp_align_exp[2:1], fp_align_exp[0]};
   assign fp_act      = {fpu_rnd, align6, align4, align2, align0, align_odd};

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pv           <= '0;
         wv           <= '0;
         gaddr        <= 1'b0;
         m_opf        <= '0;
         rsr_exp      <= '0;
         fp_rnd_exp   <= '0;
         fp_align_exp <= '0;
         for (int t = 0; t < N_THREADS; t++) begin
            ref_align[t] <= '0;
            ref_rnd[t]   <= '0;
         end
      end else begin
         m_opf <= opf;
         pv    <= {pv[2] & ~flush_w2, pv[1] & ~kill_w, pv[0], visop_e & ~dec_exp[1]};
         pc[0] <= {opf == OPF_SIAM, (opf & ~9'h002) == OPF_ALIGNADDR};
         pl[0] <= opf[1];
         pt[0] <= tid_e;
         pr[0] <= rnd_e;
         for (int i = 1; i < 4; i++) begin
            pc[i] <= pc[i-1];
            pl[i] <= pl[i-1];
            pt[i] <= pt[i-1];
            pr[i] <= pr[i-1];
         end
         gaddr <= (sraddr_d == SRADDR_GSR);
         wv    <= {wv[1] & inst_vld_w, wv[0], wsr_inst_e & gaddr};
         wt[0] <= tid_e;
         wt[1] <= wt[0];
         wt[2] <= wt[1];
         ga_w  <= gsr_align_m;
         ga_w2 <= ga_w;
         gr_w  <= gsr_rnd_m;
         gr_w2 <= gr_w;
         // wrgsr writes both fields and beats a VIS update
         for (int t = 0; t < N_THREADS; t++) begin
            if (wr_ref_w2 && int'(wt[2]) == t) begin
               ref_align[t] <= ga_w2;
               ref_rnd[t]   <= gr_w2;
            end else begin
               if (siam_ref_w2 && int'(pt[2]) == t) begin
                  ref_rnd[t] <= pr[2];
               end
               if (aa_ref_w2 && int'(pt[2]) == t) begin
                  ref_align[t] <= pl[2] ? 3'd0 - ga_w2 : ga_w2;
               end
            end
         end
         rsr_exp      <= {ref_align[tid_e], ref_rnd[tid_e]};
         fp_rnd_exp   <= ref_rnd[fp_tid][2] ? ref_rnd[fp_tid][1:0] : fsr_rnd;
         fp_align_exp <= ref_align[fp_tid];
      end
   end

   //////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////
   always @(negedge clk) begin
      if (rst_n) begin
         assert (dec_act === dec_exp)
            else report_mismatch("decode_e", 16'(dec_exp), 16'(dec_act));
         assert ({subtract, invert_rs1, invert_rs2, log_pass_rs1, log_pass_rs2,
                  log_pass_const} === m_stage_controls(m_opf))
            else report_mismatch("controls_m", 16'(m_stage_controls(m_opf)),
                                 16'({subtract, invert_rs1, invert_rs2, log_pass_rs1,
                                      log_pass_rs2, log_pass_const}));
         assert ({vis_result, vis_wen_next} === {result_ref, result_ref & ~(|pc[3])})
            else report_mismatch("result_w3", 16'({result_ref, result_ref & ~(|pc[3])}),
                                 16'({vis_result, vis_wen_next}));
         assert (gsr_wsr_w2 === (wr_ref_w2 ? thr_t'(1) << wt[2] : thr_t'(0)))
            else report_mismatch("gsr_wsr_w2",
                                 16'(wr_ref_w2 ? thr_t'(1) << wt[2] : thr_t'(0)),
                                 16'(gsr_wsr_w2));
         assert ({rsr_align_m, rsr_rnd_m} === rsr_exp)
            else report_mismatch("rsr_m", 16'(rsr_exp), 16'({rsr_align_m, rsr_rnd_m}));
         assert (fp_act === fp_exp)
            else report_mismatch("fpu_ctl", 16'(fp_exp), 16'(fp_act));
      end
   end

   // A result needs a legal VIS op in E four cycles earlier
   assert property (@(negedge clk) disable iff (!rst_n)
      vis_result |-> $past(visop_e && !illegal_vis_e, 4))
      else report_failure("vis_result without a legal VIS op four cycles earlier");
   // A GSR write strobe needs a state register write in E three cycles earlier
   assert property (@(negedge clk) disable iff (!rst_n)
      (|gsr_wsr_w2) |-> $past(wsr_inst_e, 3))
      else report_failure("gsr_wsr_w2 pulsed without a write three cycles earlier");

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////
   task automatic drive_random();
      int unsigned pick;
      logic [31:0] r, s, q;
      pick = $unsigned($random(seed)) % 6;
      r    = $random(seed);
      s    = $random(seed);
      q    = $random(seed);
      visop_e <= (r[2:0] < 3'd5);
      case (pick)
         0:       opf <= {OPF_ADD_HI, r[5:3]};
         1:       opf <= OPF_FALIGN;
         2:       opf <= {OPF_LOGIC_HI, r[8:4]};
         3:       opf <= OPF_SIAM;
         4:       opf <= OPF_ALIGNADDR | {7'd0, r[9], 1'b0};
         default: opf <= r[18:10];
      endcase
      // Mostly f0 sources so legal ops dominate
      frs1_e      <= (r[20:19] == 2'd0) ? r[25:21] : 5'd0;
      frs2_e      <= (r[27:26] == 2'd0) ? s[4:0] : 5'd0;
      frd_e       <= (s[6:5] == 2'd0) ? s[11:7] : 5'd0;
      tid_e       <= s[13:12];
      rnd_e       <= s[16:14];
      fp_tid      <= s[18:17];
      fsr_rnd     <= s[20:19];
      kill_w      <= (s[23:21] == 3'd0);
      flush_w2    <= (s[26:24] == 3'd0);
      ue_trap_w3  <= (s[29:27] == 3'd0);
      sraddr_d    <= q[0] ? SRADDR_GSR : q[7:1];
      wsr_inst_e  <= (q[9:8] == 2'd0);
      inst_vld_w  <= (q[12:10] != 3'd0);
      gsr_align_m <= q[15:13];
      gsr_rnd_m   <= q[18:16];
   endtask

   // wrgsr and a VIS update on one thread, both in E in the same cycle
   task automatic gsr_conflict(input tid_t thr, input opf_t op);
      @(posedge clk);
      sraddr_d   <= SRADDR_GSR;
      visop_e    <= 1'b0;
      wsr_inst_e <= 1'b0;
      kill_w     <= 1'b0;
      flush_w2   <= 1'b0;
      ue_trap_w3 <= 1'b0;
      inst_vld_w <= 1'b1;
      @(posedge clk);
      visop_e    <= 1'b1;
      opf        <= op;
      frs1_e     <= '0;
      frs2_e     <= '0;
      frd_e      <= '0;
      tid_e      <= thr;
      fp_tid     <= thr;
      rnd_e      <= 3'b101;
      wsr_inst_e <= 1'b1;
      @(posedge clk);
      visop_e     <= 1'b0;
      wsr_inst_e  <= 1'b0;
      gsr_align_m <= 3'd3;
      gsr_rnd_m   <= 3'b010;
      repeat (5) @(posedge clk);
   endtask

   initial begin
      seed      = 32'h29f8_4424;
      err_value = 0;
      err_other = 0;
      cycles    = 0;
      test_name = "reset";
      rst_n       <= 1'b0;
      visop_e     <= 1'b0;
      opf         <= '0;
      frs1_e      <= '0;
      frs2_e      <= '0;
      frd_e       <= '0;
      tid_e       <= '0;
      rnd_e       <= '0;
      kill_w      <= 1'b0;
      flush_w2    <= 1'b0;
      ue_trap_w3  <= 1'b0;
      sraddr_d    <= '0;
      wsr_inst_e  <= 1'b0;
      gsr_align_m <= '0;
      gsr_rnd_m   <= '0;
      inst_vld_w  <= 1'b0;
      fp_tid      <= '0;
      fsr_rnd     <= '0;
      repeat (4) @(posedge clk);
      rst_n     <= 1'b1;
      test_name = "random";
      repeat (N_OPS) begin
         @(posedge clk);
         drive_random();
      end
      test_name = "conflict";
      gsr_conflict(2'd2, OPF_SIAM);
      gsr_conflict(2'd1, OPF_ALIGNADDR | 9'h002);
      gsr_conflict(2'd0, OPF_ALIGNADDR);
      test_name = "drain";
      @(posedge clk);
      visop_e    <= 1'b0;
      wsr_inst_e <= 1'b0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      #1;
      $display("Errors: %0d wrong values, %0d other failures", err_value, err_other);
      if (err_value == 0 && err_other == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tb.f */
verilog/vis_pkg.sv
verilog/vis_opf_decode.sv
verilog/vis_pipe.sv
verilog/gsr_wr_pipe.sv
verilog/gsr_regs.sv
verilog/vis_ctl.sv
dv/tb_vis_ctl.sv

/* Makefile */
TOOL       := verilator
TOP        := tb_vis_ctl
FILELIST   := tb.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert --timescale 1ns/100ps -j 0
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/100ps
PASS_MSG   := SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
